// File: Bender.yml
package:
  name: rv32_core

sources:
  - files:
      - src/core_pkg.sv
      - src/int_regfile.sv
      - src/wr_arbiter.sv
      - src/alu_unit.sv
      - src/lsu_unit.sv
      - src/inst_dispatch.sv
      - src/rv32_core.sv
  - target: test
    files:
      - bench/core_tb.sv

// File: bench/core_tb.sv
// Drives rv32_core from bench/core_tests.txt against a 256-word data memory model
// Model covers byte addresses 0x000 to 0x3FF; reads answer after 1 to 4 cycles

`timescale 1ns/1ns

module core_tb;

    localparam int MAX_RECS  = 128;
    localparam int MEM_WORDS = 256;

    logic            aclk;
    logic            rst;
    logic            inst_valid;
    core_pkg::inst_t inst;
    logic            inst_ready;
    logic            dmem_wr;
    logic            dmem_rd;
    core_pkg::xlen_t dmem_addr;
    core_pkg::xlen_t dmem_wdata;
    logic            dmem_rvalid;
    core_pkg::xlen_t dmem_rdata;
    logic            illegal_inst;

    // Record layout is kind, address or index, data
    logic [71:0]     recs [MAX_RECS];
    core_pkg::inst_t prog [$];
    core_pkg::xlen_t st_addr [$];
    core_pkg::xlen_t st_data [$];
    logic            ill_exp [MAX_RECS];
    core_pkg::xlen_t mem [MEM_WORDS];

    logic        loaded;
    logic [31:0] lfsr;
    logic        acc_prev;
    logic        bit0;
    logic        bit1;
    int          acc_idx, n_ill, st_seen, ill_seen, rd_wait;
    int          errors, tests_ok, tests_bad, st_err0, ill_err0;
    core_pkg::xlen_t rd_addr_q;

    rv32_core DUT (
        .aclk(aclk), .rst(rst), .inst_valid(inst_valid), .inst(inst),
        .inst_ready(inst_ready), .dmem_wr(dmem_wr), .dmem_rd(dmem_rd),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_rvalid(dmem_rvalid),
        .dmem_rdata(dmem_rdata), .illegal_inst(illegal_inst)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    //////////////////////////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////////////////////////

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int word_index(input core_pkg::xlen_t a);
        return int'(a[9:2]);
    endfunction

    task automatic guard_range(input core_pkg::xlen_t a);
        if (a[31:10] != '0 || a[1:0] != 2'b00) begin
            $display("Memory access at %h lies outside the model or is unaligned", a);
            errors++;
        end
    endtask

    task automatic compare_word(input string what, input core_pkg::xlen_t got,
                                input core_pkg::xlen_t exp);
        if (got !== exp) begin
            $display("FAIL @ %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic compare_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL @ %0t ns: %s is %b, expected %b", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input bit ok);
        $display("%s: %s", name, ok ? "ok" : "mismatch");
        if (ok) begin
            tests_ok++;
        end else begin
            tests_bad++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////////////////////////

    always @(posedge aclk) begin
        if (rst) begin
            dmem_rvalid <= 1'b0;
            rd_wait = 0;
        end else begin
            dmem_rvalid <= 1'b0;
            if (dmem_rd) begin
                guard_range(dmem_addr);
                rd_addr_q = dmem_addr;
                lfsr = lfsr_next(lfsr);
                bit0 = lfsr[0];
                lfsr = lfsr_next(lfsr);
                bit1 = lfsr[0];
                rd_wait = int'({bit1, bit0}) + 1;
            end
            if (rd_wait != 0) begin
                rd_wait--;
                if (rd_wait == 0) begin
                    dmem_rvalid <= 1'b1;
                    dmem_rdata  <= mem[word_index(rd_addr_q)];
                end
            end
        end
    end

    // Stores are checked in order, then written into the model
    always @(posedge aclk) begin
        if (!rst && dmem_wr) begin
            guard_range(dmem_addr);
            if (st_seen >= st_addr.size()) begin
                $display("Unexpected store to %h at %0t ns", dmem_addr, $time);
                errors++;
            end else begin
                st_err0 = errors;
                compare_word("store address", dmem_addr, st_addr[st_seen]);
                compare_word("store data", dmem_wdata, st_data[st_seen]);
                report_test($sformatf("store %0d to %h", st_seen, st_addr[st_seen]),
                            errors == st_err0);
                st_seen++;
            end
            mem[word_index(dmem_addr)] = dmem_wdata;
        end
    end

    // illegal_inst belongs to the instruction accepted one edge earlier
    always @(posedge aclk) begin
        if (rst) begin
            acc_prev = 1'b0;
            acc_idx  = 0;
        end else begin
            if (acc_prev) begin
                ill_err0 = errors;
                compare_flag($sformatf("illegal_inst of instruction %0d", acc_idx - 1),
                             illegal_inst, ill_exp[acc_idx - 1]);
                if (ill_exp[acc_idx - 1]) begin
                    report_test($sformatf("illegal instruction %0d", acc_idx - 1),
                                errors == ill_err0);
                    ill_seen++;
                end
            end else if (illegal_inst) begin
                $display("illegal_inst pulsed at %0t ns with no instruction accepted", $time);
                errors++;
            end
            acc_prev = inst_valid && inst_ready;
            if (acc_prev) begin
                acc_idx++;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        rst         = 1'b1;
        inst_valid  = 1'b0;
        inst        = '0;
        dmem_rvalid = 1'b0;
        dmem_rdata  = '0;
        lfsr        = 32'hd6ab_7dfe;
        loaded      = 1'b0;
        n_ill       = 0;
        st_seen     = 0;
        ill_seen    = 0;
        errors      = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = core_pkg::xlen_t'(i * 4) ^ 32'ha5c3_3c5a;
        end
        for (int i = 0; i < MAX_RECS; i++) begin
            ill_exp[i] = 1'b0;
        end
        $readmemh("bench/core_tests.txt", recs);
        for (int i = 0; i < MAX_RECS; i++) begin
            case (recs[i][71:64])
                8'h01: mem[word_index(recs[i][63:32])] = recs[i][31:0];
                8'h02: prog.push_back(recs[i][31:0]);
                8'h03: begin
                    st_addr.push_back(recs[i][63:32]);
                    st_data.push_back(recs[i][31:0]);
                end
                8'h04: begin
                    ill_exp[recs[i][63:32]] = 1'b1;
                    n_ill++;
                end
                default: ;
            endcase
        end
        if (prog.size() == 0) begin
            $display("No instructions were read from bench/core_tests.txt");
            errors++;
        end
        loaded = 1'b1;

        repeat (10) @(posedge aclk);
        rst <= 1'b0;
        foreach (prog[k]) begin
            inst_valid <= 1'b1;
            inst       <= prog[k];
            // inst_ready is settled mid-cycle and holds until the next edge
            @(negedge aclk);
            while (!inst_ready) begin
                @(negedge aclk);
            end
            @(posedge aclk);
        end
        inst_valid <= 1'b0;

        wait (st_seen == st_addr.size() && ill_seen == n_ill);
        @(posedge aclk);
        $display("Summary: %0d tests passed, %0d failed, %0d errors",
                 tests_ok, tests_bad, errors);
        if (errors == 0 && tests_bad == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Forty cycles per instruction covers stalls and the slowest loads
    initial begin
        wait (loaded);
        repeat (prog.size() * 40) @(posedge aclk);
        $display("Timeout: the run did not finish within %0d cycles", prog.size() * 40);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// File: bench/core_tests.txt
// Columns: kind_address_data. Kind 01 preload, 02 instruction (data is the word),
// 03 expected store, 04 expected illegal (address column is the instruction number)
01_00000200_00001234
01_00000204_cafe0000
// ADDI x1,x0,100  LUI x2,0x12345  ADDI x3,x0,-7  SW x1 0x100  SW x2 0x104
02_00000000_06400093
02_00000000_12345137
02_00000000_ff900193
02_00000000_10102023
02_00000000_10202223
// ADD x4  SUB x5  AND x6  OR x7  XOR x8  SLT x9,x3,x1  SLT x10,x1,x3
02_00000000_00308233
02_00000000_403082b3
02_00000000_0030f333
02_00000000_0030e3b3
02_00000000_0030c433
02_00000000_0011a4b3
02_00000000_0030a533
// SW x4..x10 to 0x108..0x120
02_00000000_10402423
02_00000000_10502623
02_00000000_10602823
02_00000000_10702a23
02_00000000_10802c23
02_00000000_10902e23
02_00000000_12a02023
// LW x11 0x200, ADD x12,x11,x1 right after, SW x12 0x124
02_00000000_20002583
02_00000000_00158633
02_00000000_12c02223
// LW x13 0x204 with ADDI x14,x1,0x55 behind it, SW x14 0x128, SW x13 0x12c
02_00000000_20402683
02_00000000_05508713
02_00000000_12e02423
02_00000000_12d02623
// ADDI x0,x1,5 then SW x0 0x130
02_00000000_00508013
02_00000000_12002823
// Opcode 0x0b and an OP with funct3 5, then SW x1 0x134
02_00000000_0640008b
02_00000000_0030d0b3
02_00000000_12102a23
03_00000100_00000064
03_00000104_12345000
03_00000108_0000005d
03_0000010c_0000006b
03_00000110_00000060
03_00000114_fffffffd
03_00000118_ffffff9d
03_0000011c_00000001
03_00000120_00000000
03_00000124_00001298
03_00000128_000000b9
03_0000012c_cafe0000
03_00000130_00000000
03_00000134_00000064
04_0000001c_00000000
04_0000001d_00000000

// File: list.f
src/core_pkg.sv
src/int_regfile.sv
src/wr_arbiter.sv
src/alu_unit.sv
src/lsu_unit.sv
src/inst_dispatch.sv
src/rv32_core.sv
bench/core_tb.sv

// File: src/alu_unit.sv
// Single-entry integer ALU, one result held until its write is granted
// Busy while a result waits, so a new issue needs the previous write done

`timescale 1ns/1ns

module alu_unit (
    input  logic               aclk,
    input  logic               rst,
    input  logic               alu_issue,
    input  core_pkg::alu_op_e  alu_op,
    input  core_pkg::xlen_t    op_a,
    input  core_pkg::xlen_t    op_b,
    input  core_pkg::reg_addr_t alu_rd,
    output logic               alu_busy,
    output logic               wr_req,
    output core_pkg::reg_addr_t wr_addr,
    output core_pkg::xlen_t    wr_val,
    input  logic               wr_grant
);

    core_pkg::xlen_t result;

    always_comb begin
        case (alu_op)
            core_pkg::ALU_ADD: result = op_a + op_b;
            core_pkg::ALU_SUB: result = op_a - op_b;
            core_pkg::ALU_AND: result = op_a & op_b;
            core_pkg::ALU_OR:  result = op_a | op_b;
            core_pkg::ALU_XOR: result = op_a ^ op_b;
            // Signed compare, zero extended to a word
            core_pkg::ALU_SLT: result = core_pkg::xlen_t'($signed(op_a) < $signed(op_b));
            core_pkg::ALU_LUI: result = op_b;
            default:           result = '0;
        endcase
    end

    // Request level from issue until grant
    always_ff @(posedge aclk) begin
        if (rst) begin
            wr_req <= 1'b0;
        end else if (alu_issue) begin
            wr_req <= 1'b1;
        end else if (wr_grant) begin
            wr_req <= 1'b0;
        end
    end

    always_ff @(posedge aclk) begin
        if (alu_issue) begin
            wr_val  <= result;
            wr_addr <= alu_rd;
        end
    end

    assign alu_busy = wr_req;

    no_issue_when_busy: assert property (@(posedge aclk) disable iff (rst)
        alu_issue |-> !alu_busy);

endmodule

// File: src/core_pkg.sv
// Shared widths, RV32I encodings and state types for the execution core
// Only the integer subset listed in the decoder is encoded here

package core_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths and word types
    //////////////////////////////////////////////////////////////////////

    localparam int XLEN    = 32;
    localparam int REG_NUM = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [31:0]     inst_t;

    //////////////////////////////////////////////////////////////////////
    // Opcodes and function codes
    //////////////////////////////////////////////////////////////////////

    localparam logic [6:0] OP_REG   = 7'b0110011;
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LUI   = 7'b0110111;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    // Width code of LW and SW
    localparam logic [2:0] F3_WORD = 3'b010;

    localparam logic [6:0] F7_SUB = 7'b0100000;

    //////////////////////////////////////////////////////////////////////
    // Unit operation and state encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_STORE,
        LSU_LOAD_WAIT,
        LSU_WRITE_BACK
    } lsu_state_e;

endpackage

// File: src/inst_dispatch.sv
// Decode, scoreboard and in-order issue of one instruction per accept
// Anything outside the supported RV32I subset is flagged illegal and dropped

`timescale 1ns/1ns

module inst_dispatch (
    input  logic               aclk,
    input  logic               rst,
    input  logic               inst_valid,
    input  core_pkg::inst_t    inst,
    output logic               inst_ready,
    output logic               illegal_inst,
    output core_pkg::reg_addr_t rs1_addr,
    output core_pkg::reg_addr_t rs2_addr,
    input  core_pkg::xlen_t    rs1_val,
    input  core_pkg::xlen_t    rs2_val,
    output logic               alu_issue,
    output core_pkg::alu_op_e  alu_op,
    output core_pkg::xlen_t    op_a,
    output core_pkg::xlen_t    op_b,
    output core_pkg::reg_addr_t alu_rd,
    input  logic               alu_busy,
    output logic               lsu_issue,
    output logic               lsu_load,
    output core_pkg::xlen_t    lsu_addr,
    output core_pkg::xlen_t    lsu_wdata,
    output core_pkg::reg_addr_t lsu_rd,
    input  logic               lsu_busy,
    input  logic               wr_done,
    input  core_pkg::reg_addr_t wr_done_addr
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    core_pkg::reg_addr_t rd;
    core_pkg::xlen_t imm_i;
    core_pkg::xlen_t imm_s;
    core_pkg::xlen_t imm_u;
    logic is_reg, is_imm, is_lui, is_load, is_store;
    logic reg_legal, to_alu, to_lsu, hazard, accept;
    logic [core_pkg::REG_NUM-1:0] pending;

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    assign opcode = inst[6:0];
    assign rd     = inst[11:7];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    assign imm_i = {{20{inst[31]}}, inst[31:20]};
    assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    assign imm_u = {inst[31:12], 12'b0};

    always_comb begin
        reg_legal = 1'b0;
        alu_op    = core_pkg::ALU_ADD;
        if (opcode == core_pkg::OP_LUI) begin
            alu_op = core_pkg::ALU_LUI;
        end else if (opcode == core_pkg::OP_REG) begin
            case (funct3)
                core_pkg::F3_ADD: begin
                    reg_legal = funct7 == '0 || funct7 == core_pkg::F7_SUB;
                    alu_op = (funct7 == core_pkg::F7_SUB) ? core_pkg::ALU_SUB
                                                          : core_pkg::ALU_ADD;
                end
                core_pkg::F3_SLT: begin
                    reg_legal = funct7 == '0;
                    alu_op    = core_pkg::ALU_SLT;
                end
                core_pkg::F3_XOR: begin
                    reg_legal = funct7 == '0;
                    alu_op    = core_pkg::ALU_XOR;
                end
                core_pkg::F3_OR: begin
                    reg_legal = funct7 == '0;
                    alu_op    = core_pkg::ALU_OR;
                end
                core_pkg::F3_AND: begin
                    reg_legal = funct7 == '0;
                    alu_op    = core_pkg::ALU_AND;
                end
                default: reg_legal = 1'b0;
            endcase
        end
    end

    assign is_reg   = opcode == core_pkg::OP_REG && reg_legal;
    assign is_imm   = opcode == core_pkg::OP_IMM && funct3 == core_pkg::F3_ADD;
    assign is_lui   = opcode == core_pkg::OP_LUI;
    assign is_load  = opcode == core_pkg::OP_LOAD && funct3 == core_pkg::F3_WORD;
    assign is_store = opcode == core_pkg::OP_STORE && funct3 == core_pkg::F3_WORD;
    assign to_alu   = is_reg || is_imm || is_lui;
    assign to_lsu   = is_load || is_store;

    //////////////////////////////////////////////////////////////////////
    // Hazards and handshake
    //////////////////////////////////////////////////////////////////////

    assign rs1_addr = inst[19:15];
    assign rs2_addr = inst[24:20];

    // LUI reads no register, stores write none
    assign hazard = ((is_reg || is_imm || to_lsu) && pending[rs1_addr])
                 || ((is_reg || is_store) && pending[rs2_addr])
                 || ((to_alu || is_load) && pending[rd]);

    always_comb begin
        if (to_alu) begin
            inst_ready = !alu_busy && !hazard;
        end else if (to_lsu) begin
            inst_ready = !lsu_busy && !hazard;
        end else begin
            inst_ready = 1'b1;
        end
    end

    assign accept    = inst_valid && inst_ready;
    assign alu_issue = accept && to_alu;
    assign lsu_issue = accept && to_lsu;

    // Scoreboard, x0 is never marked
    always_ff @(posedge aclk) begin
        if (rst) begin
            pending      <= '0;
            illegal_inst <= 1'b0;
        end else begin
            if (wr_done) begin
                pending[wr_done_addr] <= 1'b0;
            end
            if (accept && (to_alu || is_load) && rd != '0) begin
                pending[rd] <= 1'b1;
            end
            illegal_inst <= accept && !to_alu && !to_lsu;
        end
    end

    // Operands for the issued unit
    assign op_a      = rs1_val;
    assign op_b      = is_reg ? rs2_val : (is_lui ? imm_u : imm_i);
    assign alu_rd    = rd;
    assign lsu_load  = is_load;
    assign lsu_addr  = rs1_val + (is_store ? imm_s : imm_i);
    assign lsu_wdata = rs2_val;
    assign lsu_rd    = rd;

    // Every register write retires an issued destination
    write_was_pending: assert property (@(posedge aclk) disable iff (rst)
        wr_done && wr_done_addr != '0 |-> pending[wr_done_addr]);

endmodule

// File: src/int_regfile.sv
// Integer registers, two asynchronous reads and one write per cycle
// No write-to-read bypass; the scoreboard keeps readers off pending registers

`timescale 1ns/1ns

module int_regfile (
    input  logic               aclk,
    input  logic               rst,
    input  core_pkg::reg_addr_t rs1_addr,
    output core_pkg::xlen_t    rs1_val,
    input  core_pkg::reg_addr_t rs2_addr,
    output core_pkg::xlen_t    rs2_val,
    input  logic               rd_wr,
    input  core_pkg::reg_addr_t rd_addr,
    input  core_pkg::xlen_t    rd_val
);

    core_pkg::xlen_t regs [core_pkg::REG_NUM];

    // x0 is cleared by reset and never written after
    always_ff @(posedge aclk) begin
        if (rst) begin
            for (int i = 0; i < core_pkg::REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wr && rd_addr != '0) begin
            regs[rd_addr] <= rd_val;
        end
    end

    assign rs1_val = regs[rs1_addr];
    assign rs2_val = regs[rs2_addr];

endmodule

// File: src/lsu_unit.sv
// Word-only load/store unit on a strobe memory port with no back-pressure
// One access at a time; read data is taken on the dmem_rvalid pulse

`timescale 1ns/1ns

module lsu_unit (
    input  logic               aclk,
    input  logic               rst,
    input  logic               lsu_issue,
    input  logic               lsu_load,
    input  core_pkg::xlen_t    lsu_addr,
    input  core_pkg::xlen_t    lsu_wdata,
    input  core_pkg::reg_addr_t lsu_rd,
    output logic               lsu_busy,
    output logic               dmem_wr,
    output logic               dmem_rd,
    output core_pkg::xlen_t    dmem_addr,
    output core_pkg::xlen_t    dmem_wdata,
    input  logic               dmem_rvalid,
    input  core_pkg::xlen_t    dmem_rdata,
    output logic               wr_req,
    output core_pkg::reg_addr_t wr_addr,
    output core_pkg::xlen_t    wr_val,
    input  logic               wr_grant
);

    core_pkg::lsu_state_e state;

    //////////////////////////////////////////////////////////////////////
    // Access sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge aclk) begin
        if (rst) begin
            state   <= core_pkg::LSU_IDLE;
            dmem_rd <= 1'b0;
        end else begin
            // Read strobe in the cycle after a load issue
            dmem_rd <= lsu_issue && lsu_load;
            case (state)
                core_pkg::LSU_IDLE: begin
                    if (lsu_issue) begin
                        state <= lsu_load ? core_pkg::LSU_LOAD_WAIT : core_pkg::LSU_STORE;
                    end
                end
                core_pkg::LSU_STORE: state <= core_pkg::LSU_IDLE;
                core_pkg::LSU_LOAD_WAIT: begin
                    if (dmem_rvalid) begin
                        state <= core_pkg::LSU_WRITE_BACK;
                    end
                end
                core_pkg::LSU_WRITE_BACK: begin
                    if (wr_grant) begin
                        state <= core_pkg::LSU_IDLE;
                    end
                end
                default: state <= core_pkg::LSU_IDLE;
            endcase
        end
    end

    // Address, data and destination captured at issue
    always_ff @(posedge aclk) begin
        if (lsu_issue) begin
            dmem_addr  <= lsu_addr;
            dmem_wdata <= lsu_wdata;
            wr_addr    <= lsu_rd;
        end
        if (state == core_pkg::LSU_LOAD_WAIT && dmem_rvalid) begin
            wr_val <= dmem_rdata;
        end
    end

    assign dmem_wr  = (state == core_pkg::LSU_STORE);
    assign wr_req   = (state == core_pkg::LSU_WRITE_BACK);
    assign lsu_busy = (state != core_pkg::LSU_IDLE);

    // The memory answers only the one read in flight
    rvalid_in_wait: assert property (@(posedge aclk) disable iff (rst)
        dmem_rvalid |-> state == core_pkg::LSU_LOAD_WAIT);

endmodule

// File: src/rv32_core.sv
// RV32I integer core without fetch; instructions arrive on a valid/ready port
// Data memory is a strobe port that accepts every access at once

`timescale 1ns/1ns

module rv32_core (
    input  logic            aclk,
    input  logic            rst,
    input  logic            inst_valid,
    input  core_pkg::inst_t inst,
    output logic            inst_ready,
    output logic            dmem_wr,
    output logic            dmem_rd,
    output core_pkg::xlen_t dmem_addr,
    output core_pkg::xlen_t dmem_wdata,
    input  logic            dmem_rvalid,
    input  core_pkg::xlen_t dmem_rdata,
    output logic            illegal_inst
);

    core_pkg::reg_addr_t rs1_addr, rs2_addr, alu_rd, lsu_rd;
    core_pkg::xlen_t rs1_val, rs2_val, op_a, op_b, lsu_addr, lsu_wdata;
    core_pkg::alu_op_e alu_op;
    logic alu_issue, alu_busy, lsu_issue, lsu_load, lsu_busy;

    // Unit write requests and the shared write port
    logic alu_req, alu_grant, lsu_req, lsu_grant, rd_wr;
    core_pkg::reg_addr_t alu_wr_addr, lsu_wr_addr, rd_addr;
    core_pkg::xlen_t alu_wr_val, lsu_wr_val, rd_val;

    inst_dispatch dispatch (
        .aclk(aclk), .rst(rst), .inst_valid(inst_valid), .inst(inst),
        .inst_ready(inst_ready), .illegal_inst(illegal_inst),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1_val(rs1_val), .rs2_val(rs2_val),
        .alu_issue(alu_issue), .alu_op(alu_op), .op_a(op_a), .op_b(op_b),
        .alu_rd(alu_rd), .alu_busy(alu_busy), .lsu_issue(lsu_issue), .lsu_load(lsu_load),
        .lsu_addr(lsu_addr), .lsu_wdata(lsu_wdata), .lsu_rd(lsu_rd), .lsu_busy(lsu_busy),
        .wr_done(rd_wr), .wr_done_addr(rd_addr)
    );

    alu_unit alu (
        .aclk(aclk), .rst(rst), .alu_issue(alu_issue), .alu_op(alu_op),
        .op_a(op_a), .op_b(op_b), .alu_rd(alu_rd), .alu_busy(alu_busy),
        .wr_req(alu_req), .wr_addr(alu_wr_addr), .wr_val(alu_wr_val), .wr_grant(alu_grant)
    );

    lsu_unit lsu (
        .aclk(aclk), .rst(rst), .lsu_issue(lsu_issue), .lsu_load(lsu_load),
        .lsu_addr(lsu_addr), .lsu_wdata(lsu_wdata), .lsu_rd(lsu_rd), .lsu_busy(lsu_busy),
        .dmem_wr(dmem_wr), .dmem_rd(dmem_rd), .dmem_addr(dmem_addr),
        .dmem_wdata(dmem_wdata), .dmem_rvalid(dmem_rvalid), .dmem_rdata(dmem_rdata),
        .wr_req(lsu_req), .wr_addr(lsu_wr_addr), .wr_val(lsu_wr_val), .wr_grant(lsu_grant)
    );

    wr_arbiter arbiter (
        .aclk(aclk), .rst(rst),
        .alu_req(alu_req), .alu_addr(alu_wr_addr), .alu_val(alu_wr_val), .alu_grant(alu_grant),
        .lsu_req(lsu_req), .lsu_addr(lsu_wr_addr), .lsu_val(lsu_wr_val), .lsu_grant(lsu_grant),
        .rd_wr(rd_wr), .rd_addr(rd_addr), .rd_val(rd_val)
    );

    int_regfile regfile (
        .aclk(aclk), .rst(rst),
        .rs1_addr(rs1_addr), .rs1_val(rs1_val), .rs2_addr(rs2_addr), .rs2_val(rs2_val),
        .rd_wr(rd_wr), .rd_addr(rd_addr), .rd_val(rd_val)
    );

endmodule

// File: src/wr_arbiter.sv
// Round-robin share of the single register write port between two units
// Requesters hold address and value stable until their grant

`timescale 1ns/1ns

module wr_arbiter (
    input  logic               aclk,
    input  logic               rst,
    input  logic               alu_req,
    input  core_pkg::reg_addr_t alu_addr,
    input  core_pkg::xlen_t    alu_val,
    output logic               alu_grant,
    input  logic               lsu_req,
    input  core_pkg::reg_addr_t lsu_addr,
    input  core_pkg::xlen_t    lsu_val,
    output logic               lsu_grant,
    output logic               rd_wr,
    output core_pkg::reg_addr_t rd_addr,
    output core_pkg::xlen_t    rd_val
);

    // Set when the LSU won the last grant
    logic last_lsu;

    assign alu_grant = alu_req && (!lsu_req || last_lsu);
    assign lsu_grant = lsu_req && (!alu_req || !last_lsu);

    always_ff @(posedge aclk) begin
        if (rst) begin
            last_lsu <= 1'b0;
        end else if (alu_grant || lsu_grant) begin
            last_lsu <= lsu_grant;
        end
    end

    // Winner drives the write port in the grant cycle
    assign rd_wr   = alu_grant || lsu_grant;
    assign rd_addr = lsu_grant ? lsu_addr : alu_addr;
    assign rd_val  = lsu_grant ? lsu_val : alu_val;

    // A load result that lost once wins the next cycle
    lsu_wait_bounded: assert property (@(posedge aclk) disable iff (rst)
        lsu_req && !lsu_grant |=> lsu_grant);

    // A waiting ALU request must not change under the arbiter
    alu_req_hold: assert property (@(posedge aclk) disable iff (rst)
        alu_req && !alu_grant |=> alu_req && $stable(alu_addr) && $stable(alu_val));

endmodule
